// ==== all.f ====
hw/lpc_fmt_pkg.sv
hw/lpc_pipe_pkg.sv
hw/skid_buffer.sv
hw/term_dispatch.sv
hw/mac_lane.sv
hw/lane_reduce.sv
hw/lpc_error_calc.sv
bench/tb_clock.sv
bench/tb_lpc_error_calc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lpc_error_calc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_lpc_error_calc.sv ====
`timescale 1ns/10ps

module tb_lpc_error_calc;

    localparam int LANES         = 2;
    localparam int MULT_LATENCY  = 3;
    localparam int RANDOM_FIRST  = 1 + lpc_pipe_pkg::MAX_ORDER;  // after the length sweep
    localparam int STALL_FIRST   = RANDOM_FIRST + 50;
    localparam int EXTREME_FIRST = STALL_FIRST + 30;
    localparam int N_VEC         = EXTREME_FIRST + 6;

    logic                iClock;
    logic                reset;
    logic                term_valid;
    logic                term_ready;
    lpc_fmt_pkg::acf_t   term_acf;
    lpc_fmt_pkg::coef_t  term_coef;
    logic                term_last;
    logic                alpha_valid;
    logic                alpha_ready;
    lpc_fmt_pkg::alpha_t alpha;

    lpc_fmt_pkg::alpha_t expected [$];   // model results in vector order
    int                  vec_len [$];
    longint              run_sum    = 0;
    int                  n_taken    = 0;
    int                  in_flight  = 0;  // claimed by the DUT, result not yet taken
    int                  cycles     = 0;
    int                  limit      = 0;
    bit                  stall_mode = 1'b0;

    tb_clock clk0 (
        .iClock (iClock),
        .reset  (reset)
    );

    lpc_error_calc #(
        .LANES        (LANES),
        .MULT_LATENCY (MULT_LATENCY)
    ) dut0 (
        .iClock      (iClock),
        .reset       (reset),
        .term_valid  (term_valid),
        .term_ready  (term_ready),
        .term_acf    (term_acf),
        .term_coef   (term_coef),
        .term_last   (term_last),
        .alpha_valid (alpha_valid),
        .alpha_ready (alpha_ready),
        .alpha       (alpha)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic send_vector(input int len, input bit extreme, input int max_gap);
        int pick;
        bit taken;
        for (int i = 0; i < len; i++) begin
            term_valid = 1'b0;
            repeat ($urandom_range(max_gap, 0)) @(negedge iClock);
            pick = $urandom_range(3, 0);
            if (extreme) begin
                term_acf  = pick[0] ? 32'sh7fff_ffff : 32'sh8000_0000;
                term_coef = pick[1] ? 16'sh7fff : 16'sh8000;
            end else begin
                term_acf  = lpc_fmt_pkg::acf_t'($urandom());
                term_coef = lpc_fmt_pkg::coef_t'($urandom());
            end
            term_last  = (i == len - 1);
            term_valid = 1'b1;
            // ready comes from a flop, so the value seen here holds to the next edge
            do begin
                taken = term_ready;
                @(negedge iClock);
            end while (!taken);
        end
        term_valid = 1'b0;
    endtask

    // model sums the exact dot product and shifts it at the last term
    always @(posedge iClock) begin
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
        if (!reset) begin
            if (term_valid && term_ready) begin
                run_sum += longint'(term_acf) * longint'(term_coef);
                if (term_last) begin
                    expected.push_back(
                        lpc_fmt_pkg::alpha_t'(run_sum >>> lpc_fmt_pkg::COEF_FRAC));
                    run_sum = 0;
                end
            end
            if (dut0.claim) begin
                in_flight++;
            end
            if (alpha_valid && alpha_ready) begin
                if (expected.size() == 0) begin
                    abort_run("alpha arrived with no vector pending");
                end
                check_value("alpha", alpha, expected.pop_front());
                n_taken++;
                in_flight--;
            end
            if (in_flight > lpc_pipe_pkg::RESULT_SLOTS + 1) begin
                abort_run($sformatf("%0d vectors accepted without a result taken",
                                    in_flight));
            end
        end
    end

    // long random stalls on the result port
    initial begin
        alpha_ready = 1'b1;
        forever begin
            @(negedge iClock);
            if (stall_mode && $urandom_range(15, 0) == 0) begin
                alpha_ready = 1'b0;
                repeat ($urandom_range(60, 10)) @(negedge iClock);
                alpha_ready = 1'b1;
            end
        end
    end

    initial begin
        int total;
        void'($urandom(52));
        term_valid = 1'b0;
        term_acf   = '0;
        term_coef  = '0;
        term_last  = 1'b0;

        vec_len.push_back(12);
        for (int n = 1; n <= lpc_pipe_pkg::MAX_ORDER; n++) begin
            vec_len.push_back(n);
        end
        for (int v = RANDOM_FIRST; v < EXTREME_FIRST; v++) begin
            vec_len.push_back($urandom_range(lpc_pipe_pkg::MAX_ORDER, 1));
        end
        vec_len.push_back(lpc_pipe_pkg::MAX_ORDER);    // longest vector at the extremes
        for (int v = EXTREME_FIRST + 1; v < N_VEC; v++) begin
            vec_len.push_back($urandom_range(lpc_pipe_pkg::MAX_ORDER, 1));
        end
        total = 0;
        foreach (vec_len[v]) begin
            total += vec_len[v];
        end
        limit = total * 4 + 200 * N_VEC;

        wait (reset === 1'b0);
        @(negedge iClock);
        check_value("alpha_valid", alpha_valid, 0);
        check_value("term_ready", term_ready, 1);

        for (int v = 0; v < N_VEC; v++) begin
            stall_mode = (v >= STALL_FIRST) && (v < EXTREME_FIRST);
            send_vector(vec_len[v], v >= EXTREME_FIRST, (v >= RANDOM_FIRST) ? 3 : 0);
            if (v < RANDOM_FIRST) begin
                wait (n_taken == v + 1);   // sweep vectors run one at a time
                @(negedge iClock);
            end
        end
        wait (n_taken == N_VEC);
        repeat (20) @(negedge iClock);       // room for a stray extra result

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic iClock,
    output logic reset
);

    initial begin
        iClock = 1'b0;
        forever #(HALF_PERIOD) iClock = ~iClock;   // 20 ns period
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge iClock);
        @(negedge iClock);
        reset = 1'b0;
    end

endmodule

// ==== hw/lpc_error_calc.sv ====
`timescale 1ns/10ps

module lpc_error_calc #(
    parameter int LANES        = lpc_pipe_pkg::DEF_LANES,
    parameter int MULT_LATENCY = lpc_pipe_pkg::DEF_MULT_LATENCY
) (
    input  logic                 iClock,
    input  logic                 reset,
    input  logic                 term_valid,
    output logic                 term_ready,
    input  lpc_fmt_pkg::acf_t    term_acf,
    input  lpc_fmt_pkg::coef_t   term_coef,
    input  logic                 term_last,
    output logic                 alpha_valid,
    input  logic                 alpha_ready,
    output lpc_fmt_pkg::alpha_t  alpha
);

    lpc_fmt_pkg::term_t  term_in;
    lpc_fmt_pkg::term_t  term_q;
    logic                in_valid;
    logic                in_ready;

    logic                slot_free;
    logic                claim;
    logic [LANES-1:0]    lane_valid;
    lpc_fmt_pkg::acf_t   lane_acf;
    lpc_fmt_pkg::coef_t  lane_coef;
    logic                flush;

    logic [LANES-1:0]    lane_done;
    lpc_fmt_pkg::acc_t   lane_sum [LANES];

    logic                res_valid;
    logic                res_ready;
    lpc_fmt_pkg::alpha_t res_alpha;

    assign term_in.acf  = term_acf;
    assign term_in.coef = term_coef;
    assign term_in.last = term_last;

    skid_buffer #(.T(lpc_fmt_pkg::term_t)) in_buf (
        .iClock    (iClock),
        .reset     (reset),
        .in_valid  (term_valid),
        .in_ready  (term_ready),
        .in_data   (term_in),
        .out_valid (in_valid),
        .out_ready (in_ready),
        .out_data  (term_q)
    );

    term_dispatch #(.LANES(LANES)) dispatch (
        .iClock     (iClock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_acf     (term_q.acf),
        .in_coef    (term_q.coef),
        .in_last    (term_q.last),
        .slot_free  (slot_free),
        .claim      (claim),
        .lane_valid (lane_valid),
        .lane_acf   (lane_acf),
        .lane_coef  (lane_coef),
        .flush      (flush)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        mac_lane #(.MULT_LATENCY(MULT_LATENCY)) lane (
            .iClock     (iClock),
            .reset      (reset),
            .term_valid (lane_valid[i]),
            .acf        (lane_acf),
            .coef       (lane_coef),
            .flush      (flush),
            .done       (lane_done[i]),
            .sum        (lane_sum[i])
        );
    end

    lane_reduce #(.LANES(LANES)) reduce (
        .iClock    (iClock),
        .reset     (reset),
        .done      (lane_done),
        .sum       (lane_sum),
        .claim     (claim),
        .res_valid (res_valid),
        .res_alpha (res_alpha),
        .res_ready (res_ready),
        .slot_free (slot_free)
    );

    skid_buffer #(.T(lpc_fmt_pkg::alpha_t)) out_buf (
        .iClock    (iClock),
        .reset     (reset),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .in_data   (res_alpha),
        .out_valid (alpha_valid),
        .out_ready (alpha_ready),
        .out_data  (alpha)
    );

endmodule

// ==== hw/lane_reduce.sv ====
`timescale 1ns/10ps

module lane_reduce #(
    parameter int LANES = 2
) (
    input  logic                  iClock,
    input  logic                  reset,
    input  logic [LANES-1:0]      done,
    input  lpc_fmt_pkg::acc_t     sum [LANES],
    input  logic                  claim,
    output logic                  res_valid,
    output lpc_fmt_pkg::alpha_t   res_alpha,
    input  logic                  res_ready,
    output logic                  slot_free
);

    logic [lpc_pipe_pkg::SLOT_W-1:0] slot_cnt;  // vectors claimed, result not yet handed on
    lpc_fmt_pkg::acc_t               total;
    logic                            all_done;
    logic                            res_fire;

    assign all_done = &done;          // lanes finish together
    assign res_fire = res_valid && res_ready;

    always_comb begin
        total = '0;
        for (int i = 0; i < LANES; i++) begin
            total = total + sum[i];
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (all_done) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge iClock) begin
        if (all_done) begin
            res_alpha <= lpc_fmt_pkg::alpha_t'(total >>> lpc_fmt_pkg::COEF_FRAC);
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            slot_cnt <= '0;
        end else begin
            case ({claim, res_fire})
                2'b10:   slot_cnt <= slot_cnt + 1'b1;
                2'b01:   slot_cnt <= slot_cnt - 1'b1;
                default: slot_cnt <= slot_cnt;
            endcase
        end
    end

    // a full output buffer also blocks a new vector,
    // so claimed vectors plus buffered results never exceed RESULT_SLOTS + 1
    assign slot_free = (slot_cnt < lpc_pipe_pkg::RESULT_SLOTS) && res_ready;

endmodule

// ==== hw/mac_lane.sv ====
`timescale 1ns/10ps

module mac_lane #(
    parameter int MULT_LATENCY = 3
) (
    input  logic               iClock,
    input  logic               reset,
    input  logic               term_valid,
    input  lpc_fmt_pkg::acf_t  acf,
    input  lpc_fmt_pkg::coef_t coef,
    input  logic               flush,
    output logic               done,
    output lpc_fmt_pkg::acc_t  sum
);

    lpc_fmt_pkg::prod_t      p_pipe [MULT_LATENCY];
    logic [MULT_LATENCY-1:0] v_pipe;
    logic [MULT_LATENCY-1:0] f_pipe;
    lpc_fmt_pkg::acc_t       acc;
    lpc_fmt_pkg::acc_t       addend;
    logic                    v_out;
    logic                    f_out;

    assign v_out = v_pipe[MULT_LATENCY-1];
    assign f_out = f_pipe[MULT_LATENCY-1];

    // sign extended product, zero on an empty beat
    assign addend = v_out ? lpc_fmt_pkg::acc_t'(p_pipe[MULT_LATENCY-1]) : '0;

    always_ff @(posedge iClock) begin
        if (reset) begin
            v_pipe <= '0;
            f_pipe <= '0;
        end else begin
            v_pipe[0] <= term_valid;
            f_pipe[0] <= flush;
            for (int k = 1; k < MULT_LATENCY; k++) begin
                v_pipe[k] <= v_pipe[k-1];
                f_pipe[k] <= f_pipe[k-1];
            end
        end
    end

    always_ff @(posedge iClock) begin
        p_pipe[0] <= lpc_fmt_pkg::prod_t'(acf) * lpc_fmt_pkg::prod_t'(coef);
        for (int k = 1; k < MULT_LATENCY; k++) begin
            p_pipe[k] <= p_pipe[k-1];
        end
    end

    // a product beside the flush belongs to the next vector
    always_ff @(posedge iClock) begin
        if (reset) begin
            acc  <= '0;
            done <= 1'b0;
        end else begin
            done <= f_out;
            if (f_out) begin
                acc <= addend;
            end else begin
                acc <= acc + addend;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (f_out) begin
            sum <= acc;
        end
    end

endmodule

// ==== hw/term_dispatch.sv ====
`timescale 1ns/10ps

module term_dispatch #(
    parameter int LANES = 2
) (
    input  logic                  iClock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lpc_fmt_pkg::acf_t     in_acf,
    input  lpc_fmt_pkg::coef_t    in_coef,
    input  logic                  in_last,
    input  logic                  slot_free,
    output logic                  claim,
    output logic [LANES-1:0]      lane_valid,
    output lpc_fmt_pkg::acf_t     lane_acf,
    output lpc_fmt_pkg::coef_t    lane_coef,
    output logic                  flush
);

    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic             in_vec;     // between first and last term of a vector
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] sel;
    logic             accept;
    logic             last_q;     // last term went out to a lane

    // only a vector start has to wait for a result slot
    assign in_ready = in_vec || slot_free;
    assign accept   = in_valid && in_ready;
    assign claim    = accept && !in_vec;

    assign sel = in_vec ? ptr : '0;   // every vector starts on lane 0

    always_ff @(posedge iClock) begin
        if (reset) begin
            in_vec     <= 1'b0;
            ptr        <= '0;
            lane_valid <= '0;
            last_q     <= 1'b0;
            flush      <= 1'b0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                lane_valid[i] <= accept && (sel == PTR_W'(i));
            end
            last_q <= accept && in_last;
            flush  <= last_q;             // one beat behind the last term
            if (accept) begin
                in_vec <= !in_last;
                if (sel == PTR_W'(LANES - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= sel + 1'b1;
                end
            end
        end
    end

    // shared payload, only the one-hot valid picks the lane
    always_ff @(posedge iClock) begin
        if (accept) begin
            lane_acf  <= in_acf;
            lane_coef <= in_coef;
        end
    end

endmodule

// ==== hw/skid_buffer.sv ====
`timescale 1ns/10ps

module skid_buffer #(
    parameter type T = logic [7:0]
) (
    input  logic iClock,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic skid_valid;
    T     skid_data;
    logic load_out;   // output register may take a new entry this cycle
    logic in_fire;

    assign in_ready = !skid_valid;    // straight from a flop
    assign in_fire  = in_valid && in_ready;
    assign load_out = !out_valid || out_ready;

    always_ff @(posedge iClock) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            // drain the skid entry first so order is kept
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_fire;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;   // output stalled, park the word
        end
    end

    always_ff @(posedge iClock) begin
        if (load_out) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_fire) begin
                out_data <= in_data;
            end
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== hw/lpc_pipe_pkg.sv ====
package lpc_pipe_pkg;

    localparam int MAX_ORDER = 32;           // longest vector

    localparam int DEF_LANES = 2;
    localparam int DEF_MULT_LATENCY = 3;

    // results allowed between the reducer and the output port
    localparam int RESULT_SLOTS = 2;

    // width of the slot counter, must hold 0..RESULT_SLOTS
    localparam int SLOT_W = $clog2(RESULT_SLOTS + 1);

endpackage

// ==== hw/lpc_fmt_pkg.sv ====
package lpc_fmt_pkg;

    // autocorrelation value, plain signed integer
    typedef logic signed [31:0] acf_t;

    // model coefficient, Q1.14
    typedef logic signed [15:0] coef_t;

    localparam int COEF_FRAC = 14;

    // full precision acf * coef
    typedef logic signed [47:0] prod_t;

    // lane sum and total, headroom for the longest vector
    typedef logic signed [55:0] acc_t;

    // total >>> COEF_FRAC
    typedef logic signed [47:0] alpha_t;

    // one term pair as it crosses the input buffer
    typedef struct packed {
        acf_t  acf;
        coef_t coef;
        logic  last;
    } term_t;

endpackage
